// File: ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // the two major opcodes that are decoded
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000; // sub, sra
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // unsigned M subset
    localparam logic [2:0] F3_MUL   = 3'b000;
    localparam logic [2:0] F3_MULHU = 3'b011;
    localparam logic [2:0] F3_DIVU  = 3'b101;
    localparam logic [2:0] F3_REMU  = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [1:0] {MD_MUL, MD_MULHU, MD_DIVU, MD_REMU} muldiv_op_t;

endpackage

// File: arch_regfile.sv
`timescale 1ns/10ps
module arch_regfile import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     commit_valid,
    input  reg_idx_t commit_rd,
    input  word_t    commit_data,
    input  reg_idx_t ra_idx,
    input  reg_idx_t rb_idx,
    input  reg_idx_t rc_idx,
    output word_t    ra_data,
    output word_t    rb_data,
    output word_t    rc_data
);
    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid && commit_rd != '0) begin
            regs[commit_rd] <= commit_data; // x0 stays zero
        end
    end

    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];
    assign rc_data = regs[rc_idx];

endmodule

// File: wb_slave_port.sv
`timescale 1ns/10ps
module wb_slave_port import ooo_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [7:0] wb_adr,
    input  word_t      wb_dat_w,
    output word_t      wb_dat_r,
    output logic       wb_ack,
    output logic       issue_valid,
    output word_t      issue_instr,
    input  logic       issue_ready,
    output reg_idx_t   rd_idx,
    input  word_t      rd_data
);
    logic req;  // request not yet acked
    logic rd_req;

    assign req = wb_cyc && wb_stb && !wb_ack;
    assign rd_req = req && !wb_we;

    assign issue_valid = req && wb_we;
    assign issue_instr = wb_dat_w;
    assign rd_idx = wb_adr[6:2]; // word address selects the register

    // write acked only once the decoder takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= rd_req || (issue_valid && issue_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) wb_dat_r <= rd_data;
    end

endmodule

// File: issue_decode.sv
`timescale 1ns/10ps
module issue_decode import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                issue_valid,
    input  word_t               issue_instr,
    output logic                issue_ready,
    output reg_idx_t            rs1_idx,
    output reg_idx_t            rs2_idx,
    input  word_t               rs1_data,
    input  word_t               rs2_data,
    input  logic [NUM_REGS-1:0] pending_mask,
    input  logic                rob_full,
    input  logic [TAG_W-1:0]    rob_tail_tag,
    output logic                rob_alloc,
    output reg_idx_t            rob_rd,
    output logic                alu_start,
    output alu_op_t             alu_op,
    output word_t               alu_a,
    output word_t               alu_b,
    output logic [TAG_W-1:0]    alu_tag,
    output logic                md_start,
    output muldiv_op_t          md_op,
    output word_t               md_a,
    output word_t               md_b,
    output logic [TAG_W-1:0]    md_tag,
    input  logic                md_busy
);
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    word_t imm_i;
    logic is_reg;
    logic alt;
    logic f7_ok;
    logic is_alu;
    logic is_md;
    logic hazard;
    logic fire;

    assign opcode = issue_instr[6:0];
    assign funct3 = issue_instr[14:12];
    assign funct7 = issue_instr[31:25];
    assign rob_rd = issue_instr[11:7];
    assign rs1_idx = issue_instr[19:15];
    assign rs2_idx = issue_instr[24:20];
    assign imm_i = {{(XLEN-12){issue_instr[31]}}, issue_instr[31:20]};

    assign is_reg = opcode == OPC_OP; // rs2 is a real source
    assign alt = funct7 == FUNCT7_ALT;
    assign f7_ok = funct7 == 7'b0 || (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SR));

    always_comb begin
        is_alu = 1'b0;
        is_md = 1'b0;
        alu_op = ALU_ADD;
        md_op = MD_MUL;
        if (is_reg && funct7 == FUNCT7_MULDIV) begin
            is_md = 1'b1;
            case (funct3)
                F3_MUL:   md_op = MD_MUL;
                F3_MULHU: md_op = MD_MULHU;
                F3_DIVU:  md_op = MD_DIVU;
                F3_REMU:  md_op = MD_REMU;
                default:  is_md = 1'b0; // signed forms dropped
            endcase
        end else if (is_reg || opcode == OPC_OP_IMM) begin
            // immediate forms only constrain funct7 on shifts
            is_alu = f7_ok || (!is_reg && funct3 != F3_SLL && funct3 != F3_SR);
            case (funct3)
                F3_ADD_SUB: alu_op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
                F3_SLL:     alu_op = ALU_SLL;
                F3_SLT:     alu_op = ALU_SLT;
                F3_SLTU:    alu_op = ALU_SLTU;
                F3_XOR:     alu_op = ALU_XOR;
                F3_SR:      alu_op = alt ? ALU_SRA : ALU_SRL;
                F3_OR:      alu_op = ALU_OR;
                default:    alu_op = ALU_AND;
            endcase
        end
    end

    // x0 is never a real dependency
    assign hazard = (rs1_idx != '0 && pending_mask[rs1_idx])
                 || (is_reg && rs2_idx != '0 && pending_mask[rs2_idx]);

    // unknown words are taken and dropped without a rob entry
    assign issue_ready = !(is_alu || is_md)
                      || (!rob_full && !hazard && !(is_md && md_busy));

    assign fire = issue_valid && issue_ready;
    assign rob_alloc = fire && (is_alu || is_md);

    assign alu_start = fire && is_alu;
    assign alu_a = rs1_data;
    assign alu_b = is_reg ? rs2_data : imm_i;
    assign alu_tag = rob_tail_tag;

    assign md_start = fire && is_md;
    assign md_a = rs1_data;
    assign md_b = rs2_data;
    assign md_tag = rob_tail_tag;

endmodule

// File: int_alu.sv
`timescale 1ns/10ps
module int_alu import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             alu_start,
    input  alu_op_t          alu_op,
    input  word_t            alu_a,
    input  word_t            alu_b,
    input  logic [TAG_W-1:0] alu_tag,
    output logic             alu_done,
    output logic [TAG_W-1:0] alu_res_tag,
    output word_t            alu_res
);
    logic [4:0] shamt;
    word_t res_d;

    assign shamt = alu_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  res_d = alu_a + alu_b;
            ALU_SUB:  res_d = alu_a - alu_b;
            ALU_AND:  res_d = alu_a & alu_b;
            ALU_OR:   res_d = alu_a | alu_b;
            ALU_XOR:  res_d = alu_a ^ alu_b;
            ALU_SLL:  res_d = alu_a << shamt;
            ALU_SRL:  res_d = alu_a >> shamt;
            ALU_SRA:  res_d = word_t'($signed(alu_a) >>> shamt);
            ALU_SLT:  res_d = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: res_d = {{(XLEN-1){1'b0}}, alu_a < alu_b};
            default:  res_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= alu_start;
        end
    end

    // result and tag travel together
    always_ff @(posedge clk) begin
        if (alu_start) begin
            alu_res <= res_d;
            alu_res_tag <= alu_tag;
        end
    end

endmodule

// File: iter_muldiv.sv
`timescale 1ns/10ps
module iter_muldiv import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             md_start,
    input  muldiv_op_t       md_op,
    input  word_t            md_a,
    input  word_t            md_b,
    input  logic [TAG_W-1:0] md_tag,
    output logic             md_busy,
    output logic             md_done,
    output logic [TAG_W-1:0] md_res_tag,
    output word_t            md_res
);
    localparam logic [5:0] LAST_STEP = 6'(XLEN);

    logic [5:0] step;
    muldiv_op_t op_q;
    logic is_div;
    logic is_mul_start;
    logic [2*XLEN-1:0] acc; // {hi, lo}: product or {remainder, quotient}
    word_t opb;             // multiplicand or divisor
    word_t mul_add;
    logic [XLEN:0] mul_sum;
    logic [XLEN:0] div_shift;
    logic [XLEN:0] div_trial;

    assign is_div = op_q == MD_DIVU || op_q == MD_REMU;
    assign is_mul_start = md_op == MD_MUL || md_op == MD_MULHU;

    // shift-add step, carry goes into the top bit
    assign mul_add = acc[0] ? opb : '0;
    assign mul_sum = {1'b0, acc[2*XLEN-1:XLEN]} + {1'b0, mul_add};

    // restoring step
    assign div_shift = {acc[2*XLEN-1:XLEN], acc[XLEN-1]};
    assign div_trial = div_shift - {1'b0, opb};

    always_ff @(posedge clk) begin
        if (rst) begin
            md_busy <= 1'b0;
            md_done <= 1'b0;
            step <= '0;
        end else begin
            md_done <= 1'b0;
            if (md_start) begin
                md_busy <= 1'b1;
                step <= '0;
            end else if (md_busy) begin
                if (step == LAST_STEP) begin
                    md_busy <= 1'b0;
                    md_done <= 1'b1;
                end else begin
                    step <= step + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (md_start) begin
            op_q <= md_op;
            md_res_tag <= md_tag;
            opb <= is_mul_start ? md_a : md_b;
            acc <= {{XLEN{1'b0}}, is_mul_start ? md_b : md_a};
        end else if (md_busy && step != LAST_STEP) begin
            if (!is_div) begin
                acc <= {mul_sum, acc[XLEN-1:1]};
            end else if (div_trial[XLEN]) begin
                acc <= {div_shift[XLEN-1:0], acc[XLEN-2:0], 1'b0}; // trial went negative
            end else begin
                acc <= {div_trial[XLEN-1:0], acc[XLEN-2:0], 1'b1};
            end
        end
    end

    // divide by zero falls out as all-ones quotient, dividend remainder
    assign md_res = (op_q == MD_MUL || op_q == MD_DIVU) ? acc[XLEN-1:0] : acc[2*XLEN-1:XLEN];

endmodule

// File: reorder_buffer.sv
`timescale 1ns/10ps
module reorder_buffer import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rob_alloc,
    input  reg_idx_t            rob_rd,
    output logic [TAG_W-1:0]    rob_tail_tag,
    output logic                rob_full,
    output logic [NUM_REGS-1:0] pending_mask,
    input  logic                alu_done,
    input  logic [TAG_W-1:0]    alu_res_tag,
    input  word_t               alu_res,
    input  logic                md_done,
    input  logic [TAG_W-1:0]    md_res_tag,
    input  word_t               md_res,
    output logic                commit_valid,
    output reg_idx_t            commit_rd,
    output word_t               commit_data
);
    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_done;
    reg_idx_t ent_rd [ROB_DEPTH];
    word_t ent_data [ROB_DEPTH];
    logic [TAG_W-1:0] head;
    logic [TAG_W-1:0] tail;
    logic [TAG_W:0] count;

    assign rob_tail_tag = tail;
    assign rob_full = count == (TAG_W+1)'(ROB_DEPTH);

    // head retires on the edge after its result lands
    assign commit_valid = ent_valid[head] && ent_done[head];
    assign commit_rd = ent_rd[head];
    assign commit_data = ent_data[head];

    always_comb begin
        pending_mask = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (ent_valid[i]) pending_mask[ent_rd[i]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= '0;
            ent_done <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (rob_alloc) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail] <= 1'b0;
                tail <= tail + 1'b1; // wraps, depth is a power of two
            end
            // both units can land in one cycle, tags differ
            if (alu_done) ent_done[alu_res_tag] <= 1'b1;
            if (md_done) ent_done[md_res_tag] <= 1'b1;
            if (commit_valid) begin
                ent_valid[head] <= 1'b0;
                head <= head + 1'b1;
            end
            count <= count + (TAG_W+1)'(rob_alloc) - (TAG_W+1)'(commit_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (rob_alloc) ent_rd[tail] <= rob_rd;
        if (alu_done) ent_data[alu_res_tag] <= alu_res;
        if (md_done) ent_data[md_res_tag] <= md_res;
    end

endmodule

// File: ooo_core_top.sv
`timescale 1ns/10ps
module ooo_core_top import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [7:0] wb_adr,
    input  word_t      wb_dat_w,
    output word_t      wb_dat_r,
    output logic       wb_ack,
    output logic       commit_valid,
    output reg_idx_t   commit_rd,
    output word_t      commit_data
);
    localparam int TAG_W = $clog2(ROB_DEPTH);

    // wishbone side to decode
    logic  issue_valid;
    logic  issue_ready;
    word_t issue_instr;
    reg_idx_t rd_idx;
    word_t rd_data;

    // operand reads
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t rs1_data;
    word_t rs2_data;

    // reorder buffer allocation
    logic [NUM_REGS-1:0] pending_mask;
    logic rob_full;
    logic rob_alloc;
    logic [TAG_W-1:0] rob_tail_tag;
    reg_idx_t rob_rd;

    // dispatch and write-back
    logic alu_start;
    alu_op_t alu_op;
    word_t alu_a;
    word_t alu_b;
    logic [TAG_W-1:0] alu_tag;
    logic alu_done;
    logic [TAG_W-1:0] alu_res_tag;
    word_t alu_res;
    logic md_start;
    muldiv_op_t md_op;
    word_t md_a;
    word_t md_b;
    logic [TAG_W-1:0] md_tag;
    logic md_busy;
    logic md_done;
    logic [TAG_W-1:0] md_res_tag;
    word_t md_res;

    wb_slave_port u_wb (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .issue_valid(issue_valid), .issue_instr(issue_instr), .issue_ready(issue_ready),
        .rd_idx(rd_idx), .rd_data(rd_data)
    );

    issue_decode #(.ROB_DEPTH(ROB_DEPTH)) u_decode (
        .issue_valid(issue_valid), .issue_instr(issue_instr), .issue_ready(issue_ready),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .pending_mask(pending_mask), .rob_full(rob_full), .rob_tail_tag(rob_tail_tag),
        .rob_alloc(rob_alloc), .rob_rd(rob_rd),
        .alu_start(alu_start), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_tag(alu_tag),
        .md_start(md_start), .md_op(md_op), .md_a(md_a), .md_b(md_b), .md_tag(md_tag),
        .md_busy(md_busy)
    );

    int_alu #(.ROB_DEPTH(ROB_DEPTH)) u_alu (
        .clk(clk), .rst(rst),
        .alu_start(alu_start), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_tag(alu_tag),
        .alu_done(alu_done), .alu_res_tag(alu_res_tag), .alu_res(alu_res)
    );

    iter_muldiv #(.ROB_DEPTH(ROB_DEPTH)) u_muldiv (
        .clk(clk), .rst(rst),
        .md_start(md_start), .md_op(md_op), .md_a(md_a), .md_b(md_b), .md_tag(md_tag),
        .md_busy(md_busy), .md_done(md_done), .md_res_tag(md_res_tag), .md_res(md_res)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk(clk), .rst(rst),
        .rob_alloc(rob_alloc), .rob_rd(rob_rd),
        .rob_tail_tag(rob_tail_tag), .rob_full(rob_full), .pending_mask(pending_mask),
        .alu_done(alu_done), .alu_res_tag(alu_res_tag), .alu_res(alu_res),
        .md_done(md_done), .md_res_tag(md_res_tag), .md_res(md_res),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data)
    );

    arch_regfile u_regfile (
        .clk(clk), .rst(rst),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data),
        .ra_idx(rs1_idx), .ra_data(rs1_data),
        .rb_idx(rs2_idx), .rb_data(rs2_data),
        .rc_idx(rd_idx), .rc_data(rd_data) // wishbone read port
    );

endmodule

// File: ooo_core_checker.sv
`timescale 1ns/10ps
module ooo_core_checker (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic commit_valid
);

    int fail_count = 0; // assertion failures so far

    // ack answers the strobe sampled one edge earlier
    ack_with_request: assert property (
        @(posedge clk) disable iff (rst) wb_ack |-> $past(wb_cyc && wb_stb)
    ) else begin
        fail_count++;
        $error("wb_ack raised without an open cycle and strobe");
    end

    ack_single_pulse: assert property (
        @(posedge clk) disable iff (rst) wb_ack |=> !wb_ack
    ) else begin
        fail_count++;
        $error("wb_ack held high for two cycles in a row");
    end

    no_commit_in_reset: assert property (
        @(posedge clk) (rst && $past(rst)) |-> !commit_valid
    ) else begin
        fail_count++;
        $error("commit_valid asserted while in reset");
    end

endmodule

// File: tb_ooo_core.sv
`timescale 1ns/10ps
module tb_ooo_core import ooo_pkg::*; ();
    localparam int CLK_PERIOD = 40;
    localparam int WAIT_LIMIT = 200; // cycles to wait out a full divide stall
    localparam int N_RAND = 8;

    logic clk;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [7:0] wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic wb_ack;
    logic commit_valid;
    reg_idx_t commit_rd;
    word_t commit_data;

    word_t row_instr[$];
    bit row_commits[$];
    reg_idx_t exp_rd[$]; // commit order the model expects
    word_t exp_data[$];
    word_t model_regs [NUM_REGS];
    logic [31:0] seed;
    int checks;
    int value_errs;
    int other_errs;

    ooo_core_top #(.ROB_DEPTH(8)) u_dut (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_data(commit_data)
    );

    bind ooo_core_top ooo_core_checker u_checker (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
        .commit_valid(commit_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t rtype(input logic [6:0] f7, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic word_t itype(input int imm, input int rs1, input logic [2:0] f3,
                                    input int rd);
        return {12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // in-order reference model of the RV32IM rules
    function automatic word_t model_exec(input word_t instr);
        logic is_op;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t a;
        word_t b;
        word_t res;
        logic [63:0] prod;
        is_op = instr[6:0] == 7'b0110011;
        f3 = instr[14:12];
        f7 = instr[31:25];
        a = model_regs[instr[19:15]];
        b = is_op ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        prod = {32'b0, a} * {32'b0, b};
        if (is_op && f7 == 7'b0000001) begin
            case (f3)
                3'b000:  res = prod[31:0];
                3'b011:  res = prod[63:32];
                3'b101:  res = (b == 0) ? 32'hffff_ffff : a / b;
                default: res = (b == 0) ? a : a % b;
            endcase
        end else begin
            case (f3)
                3'b000:  res = (is_op && f7[5]) ? a - b : a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011:  res = (a < b) ? 32'd1 : 32'd0;
                3'b100:  res = a ^ b;
                3'b101:  res = f7[5] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
        end
        return res;
    endfunction

    task automatic add_row(input word_t instr, input bit commits);
        row_instr.push_back(instr);
        row_commits.push_back(commits);
    endtask

    task automatic wait_ack(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (wb_ack) else begin
            other_errs++;
            $display("%s at %0t was never acknowledged", what, $time);
        end
    endtask

    task automatic write_instr(input word_t instr);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = '0;
        wb_dat_w = instr;
        wait_ack($sformatf("write of %h", instr));
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        @(negedge clk); // idle cycle between transfers
    endtask

    task automatic read_reg(input int idx, output word_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = {1'b0, 5'(idx), 2'b00};
        wait_ack($sformatf("read of x%0d", idx));
        data = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge clk);
    endtask

    task automatic verify_regs();
        word_t got;
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(i, got);
            checks++;
            assert (got == model_regs[i]) else begin
                value_errs++;
                $display("error at %0t: wb_dat_r for x%0d is %h, expected %h",
                         $time, i, got, model_regs[i]);
            end
        end
    endtask

    task automatic run_row(input word_t instr, input bit commits);
        reg_idx_t rd;
        word_t res;
        rd = instr[11:7];
        res = model_exec(instr);
        if (commits) begin
            exp_rd.push_back(rd);
            exp_data.push_back(res);
            if (rd != 0) model_regs[rd] = res;
        end
        write_instr(instr);
    endtask

    // commits are sampled mid-cycle while the head is stable
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            assert (exp_rd.size() != 0) else begin
                other_errs++;
                $display("commit to x%0d at %0t was not expected", commit_rd, $time);
            end
            if (exp_rd.size() != 0) begin
                checks++;
                assert (commit_rd == exp_rd[0]) else begin
                    value_errs++;
                    $display("error at %0t: commit_rd is %0d, expected %0d",
                             $time, commit_rd, exp_rd[0]);
                end
                assert (commit_data == exp_data[0]) else begin
                    value_errs++;
                    $display("error at %0t: commit_data is %h, expected %h",
                             $time, commit_data, exp_data[0]);
                end
                void'(exp_rd.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        int n;
        clk = 1'b0;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        seed = 32'h9cd0_eaa6;
        checks = 0;
        value_errs = 0;
        other_errs = 0;
        for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;

        add_row(itype(100, 0, 3'b000, 1), 1);
        add_row(itype(-7, 0, 3'b000, 2), 1);
        add_row(itype(2047, 0, 3'b000, 3), 1);
        add_row(itype(13, 0, 3'b000, 4), 1);
        add_row(rtype(7'h00, 2, 1, 3'b000, 5), 1);
        add_row(rtype(7'h20, 1, 2, 3'b000, 6), 1); // sub
        add_row(rtype(7'h00, 3, 1, 3'b111, 7), 1);
        add_row(rtype(7'h00, 4, 2, 3'b110, 8), 1);
        add_row(rtype(7'h00, 2, 1, 3'b100, 9), 1);
        add_row(rtype(7'h00, 4, 2, 3'b001, 10), 1);
        add_row(rtype(7'h00, 4, 2, 3'b101, 11), 1);
        add_row(rtype(7'h20, 4, 2, 3'b101, 12), 1); // sra
        add_row(rtype(7'h00, 1, 2, 3'b010, 13), 1);
        add_row(rtype(7'h00, 1, 2, 3'b011, 14), 1);
        add_row(itype(240, 2, 3'b111, 15), 1);
        add_row(itype(-256, 1, 3'b110, 16), 1);
        add_row(itype(1365, 2, 3'b100, 17), 1);
        add_row(itype(20, 1, 3'b001, 18), 1);
        add_row(itype(3, 2, 3'b101, 19), 1);
        add_row(itype(1024 + 3, 2, 3'b101, 20), 1); // srai
        add_row(itype(-6, 2, 3'b010, 21), 1);
        add_row(itype(-1, 1, 3'b011, 22), 1);
        add_row(rtype(7'h01, 3, 2, 3'b000, 23), 1); // mul
        add_row(rtype(7'h01, 3, 2, 3'b011, 24), 1); // mulhu
        add_row(rtype(7'h01, 4, 2, 3'b101, 25), 1);
        add_row(rtype(7'h01, 4, 2, 3'b111, 26), 1);
        add_row(rtype(7'h01, 0, 1, 3'b101, 27), 1); // divide by zero
        add_row(rtype(7'h01, 0, 1, 3'b111, 28), 1);
        add_row(rtype(7'h01, 1, 2, 3'b101, 29), 1);
        add_row(itype(55, 0, 3'b000, 30), 1); // finishes before the divide
        add_row(rtype(7'h01, 4, 3, 3'b101, 31), 1);
        add_row(itype(1, 31, 3'b000, 30), 1); // stalls on x31
        add_row(itype(5, 1, 3'b000, 0), 1);
        add_row(32'h0040_a283, 0); // lw is not decoded
        add_row(rtype(7'h01, 3, 2, 3'b001, 6), 0); // signed mulh is dropped
        for (int k = 0; k < N_RAND; k++) begin
            seed = next_rand(seed);
            add_row(itype(int'(seed[31:20]), 1 + int'(seed[9:8]), 3'b000,
                          1 + int'(seed[1:0])), 1);
        end

        repeat (3) @(negedge clk);
        rst = 1'b0;
        verify_regs();

        for (int r = 0; r < row_instr.size(); r++) begin
            run_row(row_instr[r], row_commits[r]);
        end

        n = 0;
        while (exp_rd.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (exp_rd.size() == 0) else begin
            other_errs++;
            $display("%0d expected commits never arrived", exp_rd.size());
        end
        verify_regs();

        other_errs += u_dut.u_checker.fail_count;
        $display("summary: %0d checks, %0d value errors, %0d other errors",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
ooo_pkg.sv
arch_regfile.sv
wb_slave_port.sv
issue_decode.sv
int_alu.sv
iter_muldiv.sv
reorder_buffer.sv
ooo_core_top.sv
ooo_core_checker.sv
tb_ooo_core.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_ooo_core \
    && ./obj_dir/Vtb_ooo_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
